// ==== design/sens_params.svh ====
////////////////////////////////////////////////////////////////////////////
// widths and channel count of the sensor data path
// command address map and mode register bit positions
////////////////////////////////////////////////////////////////////////////
`ifndef SENS_PARAMS_SVH
`define SENS_PARAMS_SVH

// data path sizes
`define SENS_NUM_CHN         4        // sensor channels
`define SENS_PX_WIDTH        16       // pixel as delivered by a channel
`define SENS_WORD_WIDTH      64       // memory word
`define SENS_CHN_BITS        2        // channel tag on merged output

// byte-serial command port
`define SENS_CMD_AW          16       // AL + AH
`define SENS_CMD_DW          32       // D0..D3

// address map, one mode register per channel
`define SENS_GROUP_ADDR      'h400    // channel 0 mode register
`define SENS_BASE_INC        'h040    // step to next channel

// mode register fields
`define SENS_MODE_EN_BIT     0        // 1 - channel enabled
`define SENS_MODE_16BIT_BIT  8        // 1 - 16 bpp, 0 - 8 bpp (top byte)

`endif

// ==== design/sens_px_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// memory word type shared by packers, arbiter and top level
// one 64-bit word seen as 16-bit or 8-bit pixel lanes
////////////////////////////////////////////////////////////////////////////
`include "sens_params.svh"

package sens_px_pkg;

    // lane 0 is the lsb end and carries the first pixel of the word
    typedef union packed {
        logic [`SENS_WORD_WIDTH/`SENS_PX_WIDTH-1:0][`SENS_PX_WIDTH-1:0] px16; // 4 x 16 bpp
        logic [`SENS_WORD_WIDTH/8-1:0][7:0]                             px8;  // 8 x 8 bpp
    } px_word_u;

endpackage

// ==== design/sens_cmd_deser.sv ====
////////////////////////////////////////////////////////////////////////////
// byte-serial command deserializer
// AL, AH, D0..D3 assembled into one address/data write pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module sens_cmd_deser (
    input  logic                    mclk,
    input  logic                    reset,
    input  logic [7:0]              cmd_ad,     // address/data byte
    input  logic                    cmd_stb,    // high with AL
    output logic                    wr_en,      // single cycle write
    output logic [`SENS_CMD_AW-1:0] wr_addr,
    output logic [`SENS_CMD_DW-1:0] wr_data
);

    logic [2:0]              byte_cnt;  // index of the byte now on cmd_ad
    logic                    busy;      // inside a command
    logic                    cmd_done;  // D3 just shifted in
    logic [`SENS_CMD_AW-1:0] addr_sr;   // address, lsb byte first
    logic [`SENS_CMD_DW-1:0] data_sr;   // data, lsb byte first

    always_ff @(posedge mclk) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_cnt <= 3'd0;
            cmd_done <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            cmd_done <= busy && !cmd_stb && (byte_cnt == 3'd5); // D3 on the bus
            wr_en    <= cmd_done;
            if (cmd_stb) begin                  // new or restarted command
                busy     <= 1'b1;
                byte_cnt <= 3'd1;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 3'd1;
                if (byte_cnt == 3'd5)
                    busy <= 1'b0;               // all six bytes seen
            end
        end
    end

    // shift registers and write holding registers
    always_ff @(posedge mclk) begin
        if (cmd_stb || (busy && (byte_cnt == 3'd1)))
            addr_sr <= {cmd_ad, addr_sr[`SENS_CMD_AW-1:8]}; // AL then AH
        else if (busy)
            data_sr <= {cmd_ad, data_sr[`SENS_CMD_DW-1:8]}; // D0 ends at lsb
        if (cmd_done) begin
            wr_addr <= addr_sr;         // held until next command completes
            wr_data <= data_sr;
        end
    end

    // one write per command, even with strobes arriving back to back
    a_wr_single: assert property (@(posedge mclk) disable iff (reset)
        wr_en |=> !wr_en);

endmodule

// ==== design/sens_mode_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// per-channel mode registers at group base + n * increment
// enable and 16 bpp bits kept for each channel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module sens_mode_regs (
    input  logic                     mclk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [`SENS_CMD_AW-1:0]  wr_addr,
    input  logic [`SENS_CMD_DW-1:0]  wr_data,
    output logic [`SENS_NUM_CHN-1:0] chn_en,     // channel enabled
    output logic [`SENS_NUM_CHN-1:0] chn_16bit   // 16 bpp when set
);

    logic [`SENS_NUM_CHN-1:0] hit;  // write targets this channel

    // address decode, anything outside the four registers is dropped
    always_comb begin
        for (int i = 0; i < `SENS_NUM_CHN; i++) begin
            hit[i] = wr_en &&
                (wr_addr == `SENS_CMD_AW'(`SENS_GROUP_ADDR + i * `SENS_BASE_INC));
        end
    end

    always_ff @(posedge mclk) begin
        if (reset) begin
            chn_en    <= '0;            // all off, 8 bpp
            chn_16bit <= '0;
        end else begin
            for (int i = 0; i < `SENS_NUM_CHN; i++) begin
                if (hit[i]) begin
                    chn_en[i]    <= wr_data[`SENS_MODE_EN_BIT];
                    chn_16bit[i] <= wr_data[`SENS_MODE_16BIT_BIT];
                end
            end
        end
    end

endmodule

// ==== design/sens_px_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// pixel packer for one channel
// 16-bit pixels into 64-bit words, 4 or 8 lanes, partial word at line end
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module sens_px_packer (
    input  logic                      mclk,
    input  logic                      reset,
    input  logic                      chn_en,      // from mode register
    input  logic                      chn_16bit,   // 1 - 4 lanes, 0 - 8 lanes
    // pixel side
    input  logic                      px_valid,
    input  logic [`SENS_PX_WIDTH-1:0] px_data,
    input  logic                      px_last,     // last pixel in line
    output logic                      px_ready,
    // word side
    output logic                      word_valid,
    input  logic                      word_ready,
    output sens_px_pkg::px_word_u     word_data,
    output logic                      word_last    // word closes a line
);

    localparam int LANES16 = `SENS_WORD_WIDTH / `SENS_PX_WIDTH;
    localparam int LANES8  = `SENS_WORD_WIDTH / 8;

    logic                  run;         // out of reset
    logic [2:0]            lane_cnt;    // next lane to fill
    logic [2:0]            last_lane;   // lane that closes a word
    logic                  completes;   // current pixel closes the word
    logic                  out_free;    // output register can take a word
    logic                  px_take;     // pixel accepted and kept
    sens_px_pkg::px_word_u acc;         // word being filled, upper lanes zero
    sens_px_pkg::px_word_u acc_next;    // acc with current pixel placed

    always_comb begin
        last_lane = chn_16bit ? 3'(LANES16 - 1) : 3'(LANES8 - 1);
        completes = px_last || (lane_cnt >= last_lane);
        out_free  = !word_valid || word_ready;
        // stall only the closing pixel, so a full word and a partial can coexist
        px_ready  = run && (!chn_en || !completes || out_free);
        px_take   = px_valid && px_ready && chn_en;   // disabled channel discards
        acc_next  = acc;
        if (chn_16bit)
            acc_next.px16[lane_cnt[1:0]] = px_data;
        else
            acc_next.px8[lane_cnt] = px_data[`SENS_PX_WIDTH-1:`SENS_PX_WIDTH-8]; // top byte
    end

    always_ff @(posedge mclk) begin
        if (reset) begin
            run        <= 1'b0;
            lane_cnt   <= 3'd0;
            acc        <= '0;
            word_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (!chn_en) begin          // drop any half-built word
                lane_cnt <= 3'd0;
                acc      <= '0;
            end else if (px_take) begin
                if (completes) begin
                    lane_cnt <= 3'd0;
                    acc      <= '0;     // fresh word, unused lanes stay zero
                end else begin
                    lane_cnt <= lane_cnt + 3'd1;
                    acc      <= acc_next;
                end
            end
            if (px_take && completes)
                word_valid <= 1'b1;
            else if (word_ready)
                word_valid <= 1'b0;
        end
    end

    // output register, loaded on the edge of the closing pixel
    always_ff @(posedge mclk) begin
        if (px_take && completes) begin
            word_data <= acc_next;
            word_last <= px_last;
        end
    end

    // word must not change under back-pressure from the arbiter
    a_word_hold: assert property (@(posedge mclk) disable iff (reset)
        (word_valid && !word_ready) |=>
            (word_valid && $stable(word_data) && $stable(word_last)));

endmodule

// ==== design/sens_word_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// round-robin merge of the channel word streams
// registered grant, registered output word with channel tag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module sens_word_arbiter (
    input  logic                                          mclk,
    input  logic                                          reset,
    input  logic                   [`SENS_NUM_CHN-1:0]    word_valid,
    input  sens_px_pkg::px_word_u  [`SENS_NUM_CHN-1:0]    word_data,
    input  logic                   [`SENS_NUM_CHN-1:0]    word_last,
    output logic                   [`SENS_NUM_CHN-1:0]    word_ready,
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output sens_px_pkg::px_word_u                         out_data,
    output logic                   [`SENS_CHN_BITS-1:0]   out_chn,
    output logic                                          out_last
);

    logic                      gnt_vld;    // a channel holds the grant
    logic [`SENS_CHN_BITS-1:0] gnt_chn;    // granted channel
    logic [`SENS_CHN_BITS-1:0] last_chn;   // last channel served
    logic                      out_free;   // output register empty or draining
    logic                      xfer;       // granted word moves this edge
    logic [`SENS_NUM_CHN-1:0]  req;        // candidates for next grant
    logic [`SENS_CHN_BITS-1:0] base;       // search starts after this one
    logic [`SENS_CHN_BITS-1:0] cand;
    logic                      pick_vld;
    logic [`SENS_CHN_BITS-1:0] pick_chn;

    always_comb begin
        out_free = !out_valid || out_ready;
        xfer     = gnt_vld && out_free;
        word_ready          = '0;
        word_ready[gnt_chn] = xfer;
        base = xfer ? gnt_chn : last_chn;
        req  = word_valid;
        if (xfer)
            req[gnt_chn] = 1'b0;        // its valid still shows the word leaving
        pick_vld = 1'b0;
        pick_chn = base;
        cand     = base;
        for (int k = 1; k <= `SENS_NUM_CHN; k++) begin
            cand = base + `SENS_CHN_BITS'(k);  // wraps, base itself comes last
            if (!pick_vld && req[cand]) begin
                pick_vld = 1'b1;
                pick_chn = cand;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (reset) begin
            gnt_vld   <= 1'b0;
            gnt_chn   <= '0;
            last_chn  <= `SENS_CHN_BITS'(`SENS_NUM_CHN - 1); // channel 0 first
            out_valid <= 1'b0;
        end else begin
            if (!gnt_vld || xfer) begin // grant held until its word moves
                gnt_vld <= pick_vld;
                gnt_chn <= pick_chn;
            end
            if (xfer)
                last_chn <= gnt_chn;
            if (xfer)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (xfer) begin
            out_data <= word_data[gnt_chn];
            out_chn  <= gnt_chn;
            out_last <= word_last[gnt_chn];
        end
    end

    // ready goes to at most one channel that holds a word
    a_ready_onehot: assert property (@(posedge mclk) disable iff (reset)
        $onehot0(word_ready) && ((word_ready & ~word_valid) == '0));

    // output word and tag frozen while the sink stalls
    a_out_hold: assert property (@(posedge mclk) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_chn) && $stable(out_last)));

endmodule

// ==== design/sensors_top.sv ====
////////////////////////////////////////////////////////////////////////////
// four-channel sensor data path
// command port, mode registers, per-channel packers, word arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module sensors_top (
    input  logic                                         mclk,
    input  logic                                         reset,
    // command port
    input  logic [7:0]                                   cmd_ad,    // AL-AH-D0-D1-D2-D3
    input  logic                                         cmd_stb,   // with AL
    // pixel inputs
    input  logic [`SENS_NUM_CHN-1:0]                     px_valid,
    input  logic [`SENS_NUM_CHN-1:0][`SENS_PX_WIDTH-1:0] px_data,
    input  logic [`SENS_NUM_CHN-1:0]                     px_last,
    output logic [`SENS_NUM_CHN-1:0]                     px_ready,
    // merged word output
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output sens_px_pkg::px_word_u                        out_data,
    output logic [`SENS_CHN_BITS-1:0]                    out_chn,
    output logic                                         out_last
);

    logic [7:0]                                 cmd_ad_r;   // registered command byte
    logic                                       cmd_stb_r;
    logic                                       wr_en;
    logic [`SENS_CMD_AW-1:0]                    wr_addr;
    logic [`SENS_CMD_DW-1:0]                    wr_data;
    logic [`SENS_NUM_CHN-1:0]                   chn_en;
    logic [`SENS_NUM_CHN-1:0]                   chn_16bit;
    logic [`SENS_NUM_CHN-1:0]                   word_valid;
    logic [`SENS_NUM_CHN-1:0]                   word_ready;
    sens_px_pkg::px_word_u [`SENS_NUM_CHN-1:0]  word_data;
    logic [`SENS_NUM_CHN-1:0]                   word_last;

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad;                     // one stage at the port
        if (reset)
            cmd_stb_r <= 1'b0;
        else
            cmd_stb_r <= cmd_stb;
    end

    sens_cmd_deser sens_cmd_deser_i (
        .mclk      (mclk),
        .reset     (reset),
        .cmd_ad    (cmd_ad_r),
        .cmd_stb   (cmd_stb_r),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    sens_mode_regs sens_mode_regs_i (
        .mclk      (mclk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .chn_en    (chn_en),
        .chn_16bit (chn_16bit)
    );

    for (genvar i = 0; i < `SENS_NUM_CHN; i++) begin : g_chn
        sens_px_packer sens_px_packer_i (
            .mclk       (mclk),
            .reset      (reset),
            .chn_en     (chn_en[i]),
            .chn_16bit  (chn_16bit[i]),
            .px_valid   (px_valid[i]),
            .px_data    (px_data[i]),
            .px_last    (px_last[i]),
            .px_ready   (px_ready[i]),
            .word_valid (word_valid[i]),
            .word_ready (word_ready[i]),
            .word_data  (word_data[i]),
            .word_last  (word_last[i])
        );
    end

    sens_word_arbiter sens_word_arbiter_i (
        .mclk       (mclk),
        .reset      (reset),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_last  (word_last),
        .word_ready (word_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_chn    (out_chn),
        .out_last   (out_last)
    );

endmodule

// ==== test/tb_sensors.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the four-channel sensor data path
// command writes, pixel lines, per-channel word scoreboard, assertions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "sens_params.svh"

module tb_sensors;

    localparam time DRV         = 10;       // input change after rising edge
    localparam int  T1_LEN      = 8;        // 16 bpp, two full words
    localparam int  T2_LEN      = 16;       // 8 bpp, two full words
    localparam int  T3A_LEN     = 6;        // 16 bpp, 4 + 2
    localparam int  T3B_LEN     = 11;       // 8 bpp, 8 + 3
    localparam int  T4_LEN      = 10;       // disabled channel
    localparam int  T5_LEN      = 20;       // per line, two lines per channel
    localparam int  T6_LEN      = 8;
    localparam int  TOTAL_PX    = T1_LEN + T2_LEN + T3A_LEN + T3B_LEN + T4_LEN
                                  + 2 * `SENS_NUM_CHN * T5_LEN + T6_LEN;
    localparam int  CYCLE_LIMIT = 4 * TOTAL_PX + 500;

    logic                                         mclk;
    logic                                         reset;
    logic [7:0]                                   cmd_ad;
    logic                                         cmd_stb;
    logic [`SENS_NUM_CHN-1:0]                     px_valid;
    logic [`SENS_NUM_CHN-1:0][`SENS_PX_WIDTH-1:0] px_data;
    logic [`SENS_NUM_CHN-1:0]                     px_last;
    logic [`SENS_NUM_CHN-1:0]                     px_ready;
    logic                                         out_valid;
    logic                                         out_ready;
    sens_px_pkg::px_word_u                        out_data;
    logic [`SENS_CHN_BITS-1:0]                    out_chn;
    logic                                         out_last;

    logic [`SENS_WORD_WIDTH:0] exp_q [`SENS_NUM_CHN][$];   // {last, word} per channel
    int                        pix_cnt [`SENS_NUM_CHN];    // running pixel count
    logic [31:0]               lcg_state = 32'd21;
    logic                      rand_ready;                 // randomize out_ready
    logic [`SENS_NUM_CHN-1:0]  dis_mask;                   // channels known disabled
    logic                      took;                       // word accepted last edge
    logic [`SENS_CHN_BITS-1:0] took_chn;
    logic [`SENS_NUM_CHN-1:0]  arb_valid;                  // packer words pending
    logic [`SENS_NUM_CHN-1:0]  arb_ready;                  // arbiter take strobes
    logic [`SENS_CHN_BITS-1:0] last_gnt;
    logic                      last_others;                // others waited at last take
    int                        errors;
    int                        words;
    int                        cycles;
    int                        tests_run;
    int                        test_err0;
    int                        test_words0;

    sensors_top sensors_top_i (
        .mclk      (mclk),
        .reset     (reset),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb),
        .px_valid  (px_valid),
        .px_data   (px_data),
        .px_last   (px_last),
        .px_ready  (px_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_chn   (out_chn),
        .out_last  (out_last)
    );

    assign arb_valid = sensors_top_i.word_valid;
    assign arb_ready = sensors_top_i.word_ready;

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk;               // 100 ns period
    end

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};       // upper bits, better spread
    endfunction

    // channel in 15:14, count in both the upper and the lower part
    function automatic logic [`SENS_PX_WIDTH-1:0] px_tag(input int chn, input int cnt);
        return {2'(chn), 6'(cnt), 8'(cnt)};
    endfunction

    function automatic logic head_match(input logic [`SENS_CHN_BITS-1:0] chn,
                                        input logic [`SENS_WORD_WIDTH:0] got);
        if (exp_q[chn].size() == 0)
            return 1'b0;                        // word nobody expected
        return exp_q[chn][0] == got;
    endfunction

    function automatic logic queues_empty();
        for (int c = 0; c < `SENS_NUM_CHN; c++) begin
            if (exp_q[c].size() != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic step();
        @(posedge mclk);
        #DRV;
    endtask

    // AL with strobe, then AH, D0..D3, then wait until the mode is in effect
    task automatic write_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] seq;
        int          i;
        seq = {data, addr};
        for (i = 0; i < 6; i++) begin
            cmd_stb = (i == 0);
            cmd_ad  = seq[8*i +: 8];
            step();
        end
        cmd_stb = 1'b0;
        cmd_ad  = 8'd0;
        repeat (4) step();                      // port reg, deser, wr_en, mode reg
    endtask

    task automatic write_mode(input int chn, input logic [31:0] data);
        write_cmd(16'(`SENS_GROUP_ADDR + chn * `SENS_BASE_INC), data);
    endtask

    // expected words of one line, starting at the channel's current count
    task automatic expect_line(input int chn, input int n, input logic mode16);
        sens_px_pkg::px_word_u     w;
        logic [`SENS_PX_WIDTH-1:0] px;
        int                        lanes;
        int                        lane;
        int                        i;
        lanes = mode16 ? 4 : 8;
        w     = '0;
        lane  = 0;
        for (i = 0; i < n; i++) begin
            px = px_tag(chn, pix_cnt[chn] + i);
            if (mode16)
                w.px16[lane[1:0]] = px;
            else
                w.px8[lane[2:0]] = px[15:8];    // top byte only
            lane++;
            if (lane == lanes || i == n - 1) begin
                exp_q[chn].push_back({(i == n - 1), w});
                w    = '0;                      // unused lanes of a partial stay zero
                lane = 0;
            end
        end
    endtask

    task automatic send_line(input int chn, input int n, input logic gaps);
        int   i;
        int   g;
        logic hs;
        for (i = 0; i < n; i++) begin
            if (gaps) begin
                g = lcg_next() % 3;
                repeat (g) step();              // valid low in the gap
            end
            px_valid[chn] = 1'b1;
            px_data[chn]  = px_tag(chn, pix_cnt[chn]);
            px_last[chn]  = (i == n - 1);
            hs = 1'b0;
            while (!hs) begin
                @(negedge mclk);
                hs = px_ready[chn];             // transfer on the coming edge
                step();
            end
            pix_cnt[chn]++;
            px_valid[chn] = 1'b0;
            px_last[chn]  = 1'b0;
        end
    endtask

    task automatic run_lines(input int chn, input logic mode16);
        repeat (2) begin
            expect_line(chn, T5_LEN, mode16);
            send_line(chn, T5_LEN, 1'b1);
        end
    endtask

    // wait for every expected word, then a few idle cycles for strays
    task automatic drain();
        while (!queues_empty())
            step();
        repeat (6) step();
    endtask

    task automatic start_test();
        test_err0   = errors;
        test_words0 = words;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %0s: %0d words, %0d errors", tests_run, name,
                 words - test_words0, errors - test_err0);
    endtask

    // accepted words leave the scoreboard half a cycle after the check
    always @(posedge mclk) begin
        took     <= !reset && out_valid && out_ready;
        took_chn <= out_chn;
        if (reset) begin
            last_others <= 1'b0;
            last_gnt    <= '0;
        end else if (|arb_ready) begin
            for (int c = 0; c < `SENS_NUM_CHN; c++) begin
                if (arb_ready[c])
                    last_gnt <= 2'(c);
            end
            last_others <= |(arb_valid & ~arb_ready);
        end
    end

    always @(negedge mclk) begin
        if (took) begin
            if (exp_q[took_chn].size() > 0)
                void'(exp_q[took_chn].pop_front());
            words++;
        end
    end

    always @(posedge mclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles with words missing", cycles);
            $display("tests failed");
            $finish;
        end
    end

    a_word_match: assert property (@(posedge mclk) disable iff (reset)
        (out_valid && out_ready) |-> head_match(out_chn, {out_last, out_data}))
        else begin
            errors++;
            $display("FAIL %0t: channel %0d word %h last %b not the expected one",
                     $time, $sampled(out_chn), $sampled(out_data), $sampled(out_last));
        end

    // round robin, no repeat while another channel waits
    a_no_repeat: assert property (@(posedge mclk) disable iff (reset)
        ((|arb_ready) && last_others) |-> !arb_ready[last_gnt])
        else begin
            errors++;
            $display("FAIL %0t: channel %0d served twice with other words pending",
                     $time, $sampled(last_gnt));
        end

    a_disabled_ready: assert property (@(posedge mclk) disable iff (reset)
        &(px_ready | ~dis_mask))
        else begin
            errors++;
            $display("FAIL %0t: px_ready %b low on a disabled channel",
                     $time, $sampled(px_ready));
        end

    a_reset_quiet: assert property (@(posedge mclk)
        reset |=> (px_ready == '0 && !out_valid && arb_valid == '0
                   && !sensors_top_i.wr_en))
        else begin
            errors++;
            $display("FAIL %0t: outputs active during reset", $time);
        end

    // random stall of the merged output
    initial begin
        forever begin
            step();
            out_ready = rand_ready ? ((lcg_next() % 4) != 0) : 1'b1;
        end
    end

    initial begin
        reset      = 1'b1;
        cmd_ad     = 8'd0;
        cmd_stb    = 1'b0;
        px_valid   = '0;
        px_data    = '0;
        px_last    = '0;
        out_ready  = 1'b1;
        rand_ready = 1'b0;
        dis_mask   = '0;
        errors     = 0;
        words      = 0;
        cycles     = 0;
        tests_run  = 0;
        for (int c = 0; c < `SENS_NUM_CHN; c++)
            pix_cnt[c] = 0;
        repeat (2) @(posedge mclk);
        #DRV;
        reset = 1'b0;
        step();

        start_test();
        write_mode(0, 32'h101);                 // enabled, 16 bpp
        expect_line(0, T1_LEN, 1'b1);
        send_line(0, T1_LEN, 1'b0);             // back to back
        drain();
        end_test("16 bpp packing");

        start_test();
        write_mode(1, 32'h001);                 // enabled, 8 bpp
        expect_line(1, T2_LEN, 1'b0);
        send_line(1, T2_LEN, 1'b1);
        drain();
        end_test("8 bpp packing");

        start_test();
        write_mode(2, 32'h101);
        write_mode(3, 32'h001);
        expect_line(2, T3A_LEN, 1'b1);
        send_line(2, T3A_LEN, 1'b1);
        expect_line(3, T3B_LEN, 1'b0);
        send_line(3, T3B_LEN, 1'b1);
        drain();
        end_test("partial word flush");

        start_test();
        write_mode(0, 32'h000);                 // channel 0 off
        dis_mask = 4'b0001;
        send_line(0, T4_LEN, 1'b1);             // nothing expected
        drain();
        dis_mask = '0;
        end_test("disabled channel");

        start_test();
        write_mode(0, 32'h101);
        write_mode(1, 32'h001);
        write_mode(2, 32'h101);
        write_mode(3, 32'h001);
        rand_ready = 1'b1;
        fork
            run_lines(0, 1'b1);
            run_lines(1, 1'b0);
            run_lines(2, 1'b1);
            run_lines(3, 1'b0);
        join
        rand_ready = 1'b0;
        drain();
        end_test("four channels, random stalls");

        start_test();
        write_mode(0, 32'h001);                 // channel 0 back to 8 bpp
        write_cmd(16'h0410, 32'h000);           // inside channel 0 block, not a register
        write_cmd(16'h0500, 32'h101);           // fifth channel slot, absent
        expect_line(0, T6_LEN, 1'b0);
        send_line(0, T6_LEN, 1'b1);
        drain();
        end_test("writes outside the map");

        $display("summary: %0d tests, %0d words checked, %0d errors",
                 tests_run, words, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/sens_px_pkg.sv
design/sens_cmd_deser.sv
design/sens_mode_regs.sv
design/sens_px_packer.sv
design/sens_word_arbiter.sv
design/sensors_top.sv
test/tb_sensors.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sensor data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_sensors \
    -Mdir obj_dir -o tb_sensors > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sensors > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^tests failed$" sim.log; then
    exit 1
fi
exit 0
